// File: build.f
hdl/core_pkg.sv
hdl/regfile_2w4r.sv
hdl/exec_lane.sv
hdl/issue_ctrl.sv
hdl/dual_issue_top.sv
test/dual_issue_properties.sv
test/tb_dual_issue.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_dual_issue
	./obj_dir/Vtb_dual_issue | tee /dev/stderr | grep "Test passed" > /dev/null

clean:
	rm -rf obj_dir

// File: test/tb_dual_issue.sv
`timescale 1ns/10ps

module tb_dual_issue;
	import core_pkg::*;

	// ============================================================
	// run constants
	// ============================================================

	localparam int unsigned SEED = 32'h31d391cd;
	localparam int N_SINGLE = 150;
	localparam int N_SAME = 50;
	localparam int N_B2B = 100;
	localparam int N_BP = 200;
	localparam int N_ZERO = 20;
	// same_dest and zero_reg follow each writer pair with a reader pair
	localparam int N_PAIRS = N_SINGLE + 2 * N_SAME + N_B2B + N_BP + 2 * N_ZERO;
	localparam int TIMEOUT_CYCLES = 4 * N_PAIRS + 100;

	// ============================================================
	// dut signals
	// ============================================================

	logic     rclk;
	logic     rst_n;
	logic     in_valid;
	logic     in_ready;
	logic     in_lane1_en;
	alu_op_t  lane0_op;
	reg_idx_t lane0_rd;
	reg_idx_t lane0_rs;
	reg_idx_t lane0_rt;
	data_t    lane0_imm;
	alu_op_t  lane1_op;
	reg_idx_t lane1_rd;
	reg_idx_t lane1_rs;
	reg_idx_t lane1_rt;
	data_t    lane1_imm;
	logic     out_valid;
	logic     out_ready;
	logic     out_lane1_en;
	data_t    res0;
	reg_idx_t wb_rd0;
	data_t    res1;
	reg_idx_t wb_rd1;

	// reference register state and expected results in issue order
	data_t    model_rf [NUM_REGS];
	data_t    exp_res0_q [$];
	reg_idx_t exp_rd0_q [$];
	logic     exp_l1_q [$];
	data_t    exp_res1_q [$];
	reg_idx_t exp_rd1_q [$];

	string    cur_test;
	int       errors;
	int       test_errors;
	int       test_pairs;
	int       checks;
	int       cycles;
	logic     bp_mode;
	reg_idx_t shared_rd;
	reg_idx_t prev_rd0;
	reg_idx_t prev_rd1;

	dual_issue_top u_dual_issue_top (
		.rclk         (rclk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.in_lane1_en  (in_lane1_en),
		.lane0_op     (lane0_op),
		.lane0_rd     (lane0_rd),
		.lane0_rs     (lane0_rs),
		.lane0_rt     (lane0_rt),
		.lane0_imm    (lane0_imm),
		.lane1_op     (lane1_op),
		.lane1_rd     (lane1_rd),
		.lane1_rs     (lane1_rs),
		.lane1_rt     (lane1_rt),
		.lane1_imm    (lane1_imm),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.out_lane1_en (out_lane1_en),
		.res0         (res0),
		.wb_rd0       (wb_rd0),
		.res1         (res1),
		.wb_rd1       (wb_rd1)
	);

	// ============================================================
	// reference model
	// ============================================================

	// shifts use the low 5 bits of b, addi takes the immediate as b
	function automatic data_t ref_alu(input alu_op_t op, input data_t a, input data_t b,
			input data_t imm);
		case (op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_sll:  return a << b[4:0];
			op_srl:  return a >> b[4:0];
			op_addi: return a + imm;
			default: return '0;
		endcase
	endfunction

	// register 0 always reads zero
	function automatic data_t ref_read(input reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end
		return model_rf[idx];
	endfunction

	// both lanes see the state from before the pair
	task automatic model_accept();
		data_t r0;
		data_t r1;
		r0 = ref_alu(lane0_op, ref_read(lane0_rs), ref_read(lane0_rt), lane0_imm);
		r1 = ref_alu(lane1_op, ref_read(lane1_rs), ref_read(lane1_rt), lane1_imm);
		exp_res0_q.push_back(r0);
		exp_rd0_q.push_back(lane0_rd);
		exp_l1_q.push_back(in_lane1_en);
		exp_res1_q.push_back(r1);
		exp_rd1_q.push_back(lane1_rd);
		// lane 1 lands second and wins a shared destination
		model_rf[lane0_rd] = r0;
		if (in_lane1_en) begin
			model_rf[lane1_rd] = r1;
		end
		test_pairs++;
	endtask

	// ============================================================
	// stimulus helpers
	// ============================================================

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'($urandom_range(NUM_REGS - 1, 0));
	endfunction

	function automatic reg_idx_t rand_nz_reg();
		return reg_idx_t'($urandom_range(NUM_REGS - 1, 1));
	endfunction

	task automatic random_pair(input logic dual);
		in_lane1_en = dual;
		lane0_op = alu_op_t'(3'($urandom_range(7, 0)));
		lane0_rd = rand_nz_reg();
		lane0_rs = rand_reg();
		lane0_rt = rand_reg();
		lane0_imm = $urandom();
		lane1_op = alu_op_t'(3'($urandom_range(7, 0)));
		lane1_rd = rand_nz_reg();
		lane1_rs = rand_reg();
		lane1_rt = rand_reg();
		lane1_imm = $urandom();
	endtask

	// called 2 ns after an edge, returns 2 ns after the accepting edge
	// ready is sampled mid-cycle where it is settled
	task automatic issue_pair();
		in_valid = 1'b1;
		@(negedge rclk);
		while (!in_ready) begin
			@(negedge rclk);
		end
		model_accept();
		@(posedge rclk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic set_backpressure(input logic enable);
		@(negedge rclk);
		bp_mode = enable;
		@(posedge rclk);
		#2;
	endtask

	// ============================================================
	// checking and reporting
	// ============================================================

	task automatic check_field(input string field, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("FAIL %s %s expected %h actual %h", cur_test, field, exp, act);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_output();
		data_t    e_res0;
		reg_idx_t e_rd0;
		logic     e_l1;
		data_t    e_res1;
		reg_idx_t e_rd1;
		assert (exp_res0_q.size() != 0) else begin
			$display("%s: a result came out with no pair outstanding", cur_test);
			errors++;
			test_errors++;
		end
		if (exp_res0_q.size() == 0) begin
			return;
		end
		e_res0 = exp_res0_q.pop_front();
		e_rd0 = exp_rd0_q.pop_front();
		e_l1 = exp_l1_q.pop_front();
		e_res1 = exp_res1_q.pop_front();
		e_rd1 = exp_rd1_q.pop_front();
		check_field("res0", e_res0, res0);
		check_field("wb_rd0", 32'(e_rd0), 32'(wb_rd0));
		check_field("out_lane1_en", 32'(e_l1), 32'(out_lane1_en));
		if (e_l1) begin
			check_field("res1", e_res1, res1);
			check_field("wb_rd1", 32'(e_rd1), 32'(wb_rd1));
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
		test_pairs = 0;
	endtask

	// wait for every expected result, then realign to 2 ns after an edge
	task automatic finish_test();
		do begin
			@(posedge rclk);
		end while (exp_res0_q.size() != 0);
		#2;
		$display("%-12s pairs %0d, errors %0d", cur_test, test_pairs, test_errors);
	endtask

	// ============================================================
	// clock, sink, monitor, watchdog
	// ============================================================

	initial begin
		rclk = 1'b0;
		forever #20 rclk = ~rclk;
	end

	// sink ready, random only during the backpressure test
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge rclk);
			#2;
			out_ready = bp_mode ? 1'($urandom_range(1, 0)) : 1'b1;
		end
	end

	// outputs are stable mid-cycle, the handshake completes at the next edge
	initial begin
		forever begin
			@(negedge rclk);
			if (rst_n && out_valid && out_ready) begin
				check_output();
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge rclk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout: results stopped arriving after %0d cycles", cycles);
				$display("Test failed");
				$finish;
			end
		end
	end

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		in_valid = 1'b0;
		bp_mode = 1'b0;
		errors = 0;
		checks = 0;
		random_pair(1'b0);
		for (int n = 0; n < NUM_REGS; n++) begin
			model_rf[n] = '0;
		end
		repeat (8) @(posedge rclk);
		#2;
		rst_n = 1'b1;

		start_test("reset");
		@(negedge rclk);
		check_field("out_valid", 32'd0, 32'(out_valid));
		check_field("in_ready", 32'd1, 32'(in_ready));
		finish_test();

		// op cycles through every code
		start_test("single_lane");
		for (int i = 0; i < N_SINGLE; i++) begin
			random_pair(1'b0);
			lane0_op = alu_op_t'(i[2:0]);
			issue_pair();
		end
		finish_test();

		// writer pair then a reader that copies the shared register
		start_test("same_dest");
		for (int i = 0; i < N_SAME; i++) begin
			random_pair(1'b1);
			shared_rd = rand_nz_reg();
			lane0_rd = shared_rd;
			lane1_rd = shared_rd;
			issue_pair();
			random_pair(1'b0);
			lane0_op = op_or;
			lane0_rs = shared_rd;
			lane0_rt = '0;
			issue_pair();
		end
		finish_test();

		// every source is a destination of the pair just before
		start_test("back_to_back");
		prev_rd0 = rand_nz_reg();
		prev_rd1 = rand_nz_reg();
		for (int i = 0; i < N_B2B; i++) begin
			random_pair(1'b1);
			lane0_rs = prev_rd0;
			lane0_rt = prev_rd1;
			lane1_rs = prev_rd1;
			lane1_rt = prev_rd0;
			prev_rd0 = lane0_rd;
			prev_rd1 = lane1_rd;
			issue_pair();
		end
		finish_test();

		start_test("backpressure");
		set_backpressure(1'b1);
		for (int i = 0; i < N_BP; i++) begin
			random_pair(1'b1);
			issue_pair();
		end
		finish_test();
		set_backpressure(1'b0);

		// addi into r0 from both lanes, then read r0 back
		start_test("zero_reg");
		for (int i = 0; i < N_ZERO; i++) begin
			random_pair(1'b1);
			lane0_op = op_addi;
			lane0_rd = '0;
			lane1_op = op_addi;
			lane1_rd = '0;
			issue_pair();
			random_pair(1'b1);
			lane0_op = op_or;
			lane0_rs = '0;
			lane1_op = op_add;
			lane1_rs = '0;
			lane1_rt = '0;
			issue_pair();
		end
		finish_test();

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: test/dual_issue_properties.sv
`timescale 1ns/10ps

module dual_issue_properties (
	input logic rclk,
	input logic rst_n,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input logic out_lane1_en
);

	// ============================================================
	// handshake rules
	// ============================================================

	// only a full writeback stage that the sink refuses stops the pipe
	a_ready_vs_stall: assert property (@(posedge rclk) disable iff (!rst_n)
		in_ready == !(out_valid && !out_ready))
		else $error("in_ready does not follow the output stall condition");

	// stage valid bits are cleared while reset is held
	a_idle_in_reset: assert property (@(posedge rclk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// a refused result stays on the port unchanged
	a_stall_hold: assert property (@(posedge rclk) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_lane1_en)))
		else $error("stalled output did not hold");

endmodule

bind issue_ctrl dual_issue_properties u_props (
	.rclk         (rclk),
	.rst_n        (rst_n),
	.in_ready     (in_ready),
	.out_valid    (out_valid),
	.out_ready    (out_ready),
	.out_lane1_en (out_lane1_en)
);

// File: hdl/dual_issue_top.sv
`timescale 1ns/10ps

module dual_issue_top (
	input  logic               rclk,
	input  logic               rst_n,
	// input handshake, one instruction pair per transfer
	input  logic               in_valid,
	output logic               in_ready,
	input  logic               in_lane1_en,
	// lane 0 fields
	input  core_pkg::alu_op_t  lane0_op,
	input  core_pkg::reg_idx_t lane0_rd,
	input  core_pkg::reg_idx_t lane0_rs,
	input  core_pkg::reg_idx_t lane0_rt,
	input  core_pkg::data_t    lane0_imm,
	// lane 1 fields
	input  core_pkg::alu_op_t  lane1_op,
	input  core_pkg::reg_idx_t lane1_rd,
	input  core_pkg::reg_idx_t lane1_rs,
	input  core_pkg::reg_idx_t lane1_rt,
	input  core_pkg::data_t    lane1_imm,
	// output handshake, results of one pair
	output logic               out_valid,
	input  logic               out_ready,
	output logic               out_lane1_en,
	output core_pkg::data_t    res0,
	output core_pkg::reg_idx_t wb_rd0,
	output core_pkg::data_t    res1,
	output core_pkg::reg_idx_t wb_rd1
);
	import core_pkg::*;

	// ============================================================
	// internal nets
	// ============================================================

	logic advance;
	logic exec_lane1_en;
	logic wr0;
	logic wr1;

	// raw register file read data
	data_t rf_o0;
	data_t rf_o1;
	data_t rf_o2;
	data_t rf_o3;

	// lane 1 operands, held at zero when lane 1 is idle
	data_t l1_opa;
	data_t l1_opb;

	assign l1_opa = exec_lane1_en ? rf_o2 : '0;
	assign l1_opb = exec_lane1_en ? rf_o3 : '0;

	// ============================================================
	// control
	// ============================================================

	issue_ctrl u_issue_ctrl (
		.rclk          (rclk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_lane1_en   (in_lane1_en),
		.in_ready      (in_ready),
		.advance       (advance),
		.exec_lane1_en (exec_lane1_en),
		.out_valid     (out_valid),
		.out_lane1_en  (out_lane1_en),
		.out_ready     (out_ready),
		.wr0           (wr0),
		.wr1           (wr1)
	);

	// ============================================================
	// register file, lane 0 on ports 0/1, lane 1 on ports 2/3
	// ============================================================

	regfile_2w4r u_regfile (
		.rclk    (rclk),
		.rst_n   (rst_n),
		.advance (advance),
		.wr0     (wr0),
		.wr1     (wr1),
		.wa0     (wb_rd0),
		.wa1     (wb_rd1),
		.i0      (res0),
		.i1      (res1),
		.ra0     (lane0_rs),
		.ra1     (lane0_rt),
		.ra2     (lane1_rs),
		.ra3     (lane1_rt),
		.o0      (rf_o0),
		.o1      (rf_o1),
		.o2      (rf_o2),
		.o3      (rf_o3)
	);

	// ============================================================
	// execute lanes
	// ============================================================

	exec_lane u_lane0 (
		.rclk    (rclk),
		.rst_n   (rst_n),
		.advance (advance),
		.op      (lane0_op),
		.rd      (lane0_rd),
		.imm     (lane0_imm),
		.opa     (rf_o0),
		.opb     (rf_o1),
		.res     (res0),
		.wb_rd   (wb_rd0)
	);

	exec_lane u_lane1 (
		.rclk    (rclk),
		.rst_n   (rst_n),
		.advance (advance),
		.op      (lane1_op),
		.rd      (lane1_rd),
		.imm     (lane1_imm),
		.opa     (l1_opa),
		.opb     (l1_opb),
		.res     (res1),
		.wb_rd   (wb_rd1)
	);

endmodule

// File: hdl/issue_ctrl.sv
`timescale 1ns/10ps

module issue_ctrl (
	input  logic rclk,
	input  logic rst_n,
	// input handshake
	input  logic in_valid,
	input  logic in_lane1_en,
	output logic in_ready,
	// pipeline control
	output logic advance,
	output logic exec_lane1_en,
	// output handshake
	output logic out_valid,
	output logic out_lane1_en,
	input  logic out_ready,
	// register file write enables
	output logic wr0,
	output logic wr1
);

	// ============================================================
	// stage-valid bits
	// ============================================================

	// execute stage, holds the pair whose operands are being read
	logic ex_valid;
	logic ex_l1;

	// writeback stage, holds the pair on the output port
	logic wb_valid;
	logic wb_l1;

	// the whole pipe moves together, so a stall anywhere
	// is a full writeback stage that the sink will not take
	assign advance = !wb_valid || out_ready;

	// accept a new pair exactly when the execute stage moves on
	assign in_ready = advance;

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_l1    <= 1'b0;
			wb_valid <= 1'b0;
			wb_l1    <= 1'b0;
		end else if (advance) begin
			// lane 1 enable only means something with a valid pair
			ex_valid <= in_valid;
			ex_l1    <= in_valid && in_lane1_en;
			wb_valid <= ex_valid;
			wb_l1    <= ex_l1;
		end
	end

	// ============================================================
	// outputs
	// ============================================================

	assign exec_lane1_en = ex_l1;

	assign out_valid    = wb_valid;
	assign out_lane1_en = wb_l1;

	// register writes commit with the output handshake
	// lane 1 writes only when it was issued with the pair
	assign wr0 = wb_valid && out_ready;
	assign wr1 = wr0 && wb_l1;

endmodule

// File: hdl/exec_lane.sv
`timescale 1ns/10ps

module exec_lane (
	input  logic               rclk,
	input  logic               rst_n,
	input  logic               advance,
	// raw lane fields from the input port
	input  core_pkg::alu_op_t  op,
	input  core_pkg::reg_idx_t rd,
	input  core_pkg::data_t    imm,
	// operands from the register file, valid in the execute stage
	input  core_pkg::data_t    opa,
	input  core_pkg::data_t    opb,
	// writeback stage result
	output core_pkg::data_t    res,
	output core_pkg::reg_idx_t wb_rd
);
	import core_pkg::*;

	// ============================================================
	// execute stage fields
	// ============================================================

	// captured with the read addresses so they line up with o0..o3
	alu_op_t  ex_op;
	reg_idx_t ex_rd;
	data_t    ex_imm;

	data_t    alu_b;
	data_t    alu_out;
	logic [4:0] shamt;

	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			ex_op <= op_add;
			ex_rd <= '0;
		end else if (advance) begin
			ex_op <= op;
			ex_rd <= rd;
		end
	end

	always_ff @(posedge rclk) begin
		if (advance) begin
			ex_imm <= imm;
		end
	end

	// ============================================================
	// alu
	// ============================================================

	// immediate replaces the second source only for addi
	assign alu_b = (ex_op == op_addi) ? ex_imm : opb;
	assign shamt = alu_b[4:0];

	always_comb begin
		unique case (ex_op)
			op_add:  alu_out = opa + alu_b;
			op_sub:  alu_out = opa - alu_b;
			op_and:  alu_out = opa & alu_b;
			op_or:   alu_out = opa | alu_b;
			op_xor:  alu_out = opa ^ alu_b;
			op_sll:  alu_out = opa << shamt;
			op_srl:  alu_out = opa >> shamt;
			op_addi: alu_out = opa + alu_b;
			default: alu_out = '0;
		endcase
	end

	// ============================================================
	// writeback stage registers
	// ============================================================

	// held while stalled, these drive both the output and the write port
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			wb_rd <= '0;
		end else if (advance) begin
			wb_rd <= ex_rd;
		end
	end

	always_ff @(posedge rclk) begin
		if (advance) begin
			res <= alu_out;
		end
	end

endmodule

// File: hdl/regfile_2w4r.sv
`timescale 1ns/10ps

module regfile_2w4r (
	input  logic               rclk,
	input  logic               rst_n,
	input  logic               advance,
	// write ports, port 1 is the younger lane
	input  logic               wr0,
	input  logic               wr1,
	input  core_pkg::reg_idx_t wa0,
	input  core_pkg::reg_idx_t wa1,
	input  core_pkg::data_t    i0,
	input  core_pkg::data_t    i1,
	// read addresses, captured on advance
	input  core_pkg::reg_idx_t ra0,
	input  core_pkg::reg_idx_t ra1,
	input  core_pkg::reg_idx_t ra2,
	input  core_pkg::reg_idx_t ra3,
	output core_pkg::data_t    o0,
	output core_pkg::data_t    o1,
	output core_pkg::data_t    o2,
	output core_pkg::data_t    o3
);
	import core_pkg::*;

	// ============================================================
	// storage
	// ============================================================

	// one bank per write port
	data_t bank0 [NUM_REGS];
	data_t bank1 [NUM_REGS];

	// live-value table, a set bit means bank1 holds the newest copy
	logic [NUM_REGS-1:0] live;

	// registered read addresses
	reg_idx_t rra0;
	reg_idx_t rra1;
	reg_idx_t rra2;
	reg_idx_t rra3;

	// start banks at zero so simulation sees no x on first reads
	initial begin
		for (int n = 0; n < NUM_REGS; n++) begin
			bank0[n] = '0;
			bank1[n] = '0;
		end
	end

	// ============================================================
	// write side
	// ============================================================

	always @(posedge rclk) begin
		if (wr0) begin
			bank0[wa0] <= i0;
		end
		if (wr1) begin
			bank1[wa1] <= i1;
		end
	end

	// port 1 assignment comes last so it wins on a shared address
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			live <= '0;
		end else begin
			if (wr0) begin
				live[wa0] <= 1'b0;
			end
			if (wr1) begin
				live[wa1] <= 1'b1;
			end
		end
	end

	// ============================================================
	// read side
	// ============================================================

	// addresses hold while the pipeline is stalled, data is re-read
	always_ff @(posedge rclk or negedge rst_n) begin
		if (!rst_n) begin
			rra0 <= '0;
			rra1 <= '0;
			rra2 <= '0;
			rra3 <= '0;
		end else if (advance) begin
			rra0 <= ra0;
			rra1 <= ra1;
			rra2 <= ra2;
			rra3 <= ra3;
		end
	end

	// r0 is hardwired zero, then same-cycle bypass with port 1 first,
	// then whichever bank the live table points at
	function automatic data_t read_port(input reg_idx_t ra);
		if (ra == '0) begin
			return '0;
		end else if (wr1 && (ra == wa1)) begin
			return i1;
		end else if (wr0 && (ra == wa0)) begin
			return i0;
		end else begin
			return live[ra] ? bank1[ra] : bank0[ra];
		end
	endfunction

	always_comb begin
		o0 = read_port(rra0);
		o1 = read_port(rra1);
		o2 = read_port(rra2);
		o3 = read_port(rra3);
	end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

	// ============================================================
	// datapath widths
	// ============================================================

	// register data width
	localparam int DATA_W = 32;

	// register index width, 64 architectural registers
	localparam int REG_ADDR_W = 6;
	localparam int NUM_REGS = 64;

	// ============================================================
	// shared types
	// ============================================================

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [REG_ADDR_W-1:0] reg_idx_t;

	// alu operation code, one per lane
	// shifts take the low 5 bits of operand b
	// op_addi swaps operand b for the immediate
	typedef enum logic [2:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_or   = 3'd3,
		op_xor  = 3'd4,
		op_sll  = 3'd5,
		op_srl  = 3'd6,
		op_addi = 3'd7
	} alu_op_t;

endpackage
